// File: project.f
common/pcs_pkg.sv
pcs_rx/pcs_rx_decoder.sv
design/pcs_loopback.sv
pcs_tx/pcs_tx_encoder.sv
design/pcs_loopback_top.sv
dv/pcs_loopback_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the PCS loopback testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f project.f --top-module pcs_loopback_tb; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/Vpcs_loopback_tb > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error status"
	exit 1
fi

cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

if ! grep -q "All checks passed" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi

exit 0

// File: dv/pcs_loopback_tb.sv
// PCS loopback testbench with clocks, reset, stimulus table, expected blocks and checks
`timescale 1ns/1ps

module pcs_loopback_tb;
	import pcs_pkg::*;

	localparam logic [7:0] TERM_CODES [8] = '{BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
		BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7};

	logic        rx_clk;
	logic        tx_clk;
	logic        arst_n_i;
	pcs_block_t  rx_block_i;
	pcs_block_t  tx_block_o;
	logic        tx_arst_n_o;

	// Stimulus table with one entry per block
	string       row_name [$];
	pcs_block_t  row_blk [$];
	pcs_block_t  row_exp [$];
	int          row_gap [$]; // Idle blocks driven ahead of the row

	// Blocks on their way through the DUT with the oldest at the front
	string       exp_name_q [$];
	pcs_block_t  exp_blk_q [$];

	pcs_block_t  idle_blk;
	pcs_block_t  err_blk;
	pcs_block_t  exp_blk;
	string       exp_name;
	logic [31:0] rng_state;
	logic        aligned;
	logic        monitor_on;
	int          errors;
	int          checked;
	int          cycles;
	int          cycle_limit;
	int          low_edges;

	pcs_loopback_top dut0 (
		.rx_clk      (rx_clk),
		.tx_clk      (tx_clk),
		.arst_n_i    (arst_n_i),
		.rx_block_i  (rx_block_i),
		.tx_block_o  (tx_block_o),
		.tx_arst_n_o (tx_arst_n_o)
	);

	initial begin
		rx_clk = 1'b0;
		forever #2 rx_clk = ~rx_clk;
	end

	// Same frequency as rx_clk and one nanosecond behind it
	initial begin
		tx_clk = 1'b0;
		#1;
		forever #2 tx_clk = ~tx_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [63:0] next_rand64();
		logic [31:0] hi;
		rng_state = xorshift32(rng_state);
		hi        = rng_state;
		rng_state = xorshift32(rng_state);
		return {hi, rng_state};
	endfunction

	function automatic logic [55:0] rand56();
		logic [63:0] r;
		r = next_rand64();
		return r[55:0];
	endfunction

	function automatic pcs_block_t make_ctrl_block(input logic [7:0] bt, input logic [55:0] payload);
		return {payload, bt, SYNC_CTRL};
	endfunction

	function automatic pcs_block_t make_data_block(input logic [63:0] data);
		return {data, SYNC_DATA};
	endfunction

	// Terminate with n random data bytes at the bottom and all-zero idle codes above them
	function automatic pcs_block_t make_term_block(input int n);
		logic [63:0] r;
		logic [55:0] payload;
		r       = next_rand64();
		payload = '0;
		for (int i = 0; i < 7; i++) begin
			if (i < n)
				payload[8*i +: 8] = r[8*i +: 8];
		end
		return make_ctrl_block(TERM_CODES[n[2:0]], payload);
	endfunction

	function automatic void add_row(input string name, input pcs_block_t blk,
		input pcs_block_t expected, input int gap);
		row_name.push_back(name);
		row_blk.push_back(blk);
		row_exp.push_back(expected);
		row_gap.push_back(gap);
	endfunction

	function automatic void build_table();
		pcs_block_t  blk;
		logic [55:0] r56;
		string       name;
		for (int n = 0; n < 8; n++) begin
			name = $sformatf("frame_term%0d", n);
			blk  = make_ctrl_block(BT_START0, rand56());
			add_row(name, blk, blk, 2);
			for (int d = 0; d < 2; d++) begin
				blk = make_data_block(next_rand64());
				add_row(name, blk, blk, 0);
			end
			blk = make_term_block(n);
			add_row(name, blk, blk, 0);
		end
		r56 = rand56();
		blk = make_ctrl_block(BT_START4, {r56[55:32], 32'h0}); // Idle lanes 0 to 3 and 4 pad bits
		add_row("start_lane4", blk, blk, 2);
		blk = make_data_block(next_rand64());
		add_row("start_lane4", blk, blk, 0);
		blk = make_term_block(3);
		add_row("start_lane4", blk, blk, 0);

		// Framing errors that each recover on the next start
		add_row("data_outside_frame", make_data_block(next_rand64()), err_blk, 2);
		blk = make_ctrl_block(BT_START0, rand56());
		add_row("start_inside_frame", blk, blk, 2);
		blk = make_data_block(next_rand64());
		add_row("start_inside_frame", blk, blk, 0);
		add_row("start_inside_frame", make_ctrl_block(BT_START0, rand56()), err_blk, 0);
		blk = make_ctrl_block(BT_START0, rand56());
		add_row("idle_inside_frame", blk, blk, 0);
		add_row("idle_inside_frame", idle_blk, err_blk, 0);
		blk = make_ctrl_block(BT_START0, rand56());
		add_row("recover_frame", blk, blk, 0);
		blk = make_data_block(next_rand64());
		add_row("recover_frame", blk, blk, 0);
		blk = make_term_block(4);
		add_row("recover_frame", blk, blk, 0);

		// Coding errors
		add_row("sync_00", {next_rand64(), 2'b00}, err_blk, 2);
		add_row("sync_11", {next_rand64(), 2'b11}, err_blk, 2);
		add_row("type_4b", make_ctrl_block(8'h4b, rand56()), err_blk, 2);
		add_row("type_unknown", make_ctrl_block(8'h00, 56'h0), err_blk, 2);
		r56          = {8{CC_IDLE}};
		r56[21 +: 7] = 7'h07; // One bad control code in lane 3
		add_row("idle_bad_code", make_ctrl_block(BT_IDLE, r56), err_blk, 2);
		blk = make_ctrl_block(BT_START0, rand56());
		add_row("recover_after_coding", blk, blk, 2);
		blk = make_term_block(0);
		add_row("recover_after_coding", blk, blk, 0);
	endfunction

	task automatic drive_block(input string name, input pcs_block_t blk, input pcs_block_t expected);
		@(negedge rx_clk);
		rx_block_i = blk;
		exp_name_q.push_back(name);
		exp_blk_q.push_back(expected);
	endtask

	// Output idles are skipped until the first frame shows up and every block after that is compared
	always @(negedge tx_clk) begin
		if (monitor_on) begin
			if (!aligned && tx_block_o != idle_blk) begin
				while (exp_blk_q.size() > 0 && exp_blk_q[0] == idle_blk) begin
					exp_blk  = exp_blk_q.pop_front();
					exp_name = exp_name_q.pop_front();
				end
				aligned = 1'b1;
			end
			if (aligned && exp_blk_q.size() > 0) begin
				exp_blk  = exp_blk_q.pop_front();
				exp_name = exp_name_q.pop_front();
				checked++;
				assert (tx_block_o == exp_blk) else begin
					errors++;
					$display("mismatch %s expected %h actual %h", exp_name, exp_blk, tx_block_o);
				end
			end
		end
	end

	always @(posedge rx_clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run did not finish within %0d rx_clk cycles", cycle_limit);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		int total;
		arst_n_i    = 1'b0;
		rng_state   = 32'hd1b;
		idle_blk    = make_ctrl_block(BT_IDLE, {8{CC_IDLE}});
		err_blk     = make_ctrl_block(BT_IDLE, {8{CC_ERROR}});
		rx_block_i  = idle_blk;
		aligned     = 1'b0;
		monitor_on  = 1'b0;
		errors      = 0;
		checked     = 0;
		cycles      = 0;
		low_edges   = 0;
		build_table();
		total = row_blk.size();
		for (int r = 0; r < row_gap.size(); r++)
			total += row_gap[r];
		cycle_limit = total + 40;

		repeat (4) @(negedge rx_clk);
		assert (tx_arst_n_o == 1'b0) else begin
			errors++;
			$display("tx reset was not held while arst_n_i was low");
		end
		arst_n_i = 1'b1;
		@(negedge tx_clk);
		while (tx_arst_n_o == 1'b0) begin
			low_edges++;
			@(negedge tx_clk);
		end
		assert (low_edges >= 2) else begin
			errors++;
			$display("tx reset was released %0d tx_clk edges after arst_n_i, too early", low_edges);
		end
		repeat (3) begin
			assert (tx_block_o == idle_blk) else begin
				errors++;
				$display("mismatch reset expected %h actual %h", idle_blk, tx_block_o);
			end
			@(negedge tx_clk);
		end
		monitor_on = 1'b1;

		for (int r = 0; r < row_blk.size(); r++) begin
			for (int g = 0; g < row_gap[r]; g++)
				drive_block("idle_gap", idle_blk, idle_blk);
			drive_block(row_name[r], row_blk[r], row_exp[r]);
		end
		while (!(aligned && exp_blk_q.size() == 0)) begin
			@(negedge rx_clk);
			rx_block_i = idle_blk;
		end

		$display("errors: %0d, blocks checked: %0d", errors, checked);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: design/pcs_loopback_top.sv
// Loopback top level with the receive decoder, the clock crossing and the transmit encoder
`timescale 1ns/1ps

module pcs_loopback_top (
	input  logic                rx_clk,
	input  logic                tx_clk,
	input  logic                arst_n_i,
	input  pcs_pkg::pcs_block_t rx_block_i,
	output pcs_pkg::pcs_block_t tx_block_o,
	output logic                tx_arst_n_o
);
	import pcs_pkg::*;

	pcs_word_s rx_word; // Decoded on rx_clk
	pcs_word_s tx_word; // Same word retimed to tx_clk

	pcs_rx_decoder u_rx_decoder (
		.rx_clk     (rx_clk),
		.arst_n_i   (arst_n_i),
		.rx_block_i (rx_block_i),
		.rx_word_o  (rx_word)
	);

	pcs_loopback u_loopback (
		.rx_clk      (rx_clk),
		.tx_clk      (tx_clk),
		.arst_n_i    (arst_n_i),
		.rx_word_i   (rx_word),
		.tx_arst_n_o (tx_arst_n_o),
		.tx_word_o   (tx_word)
	);

	// Encoder runs in the transmit reset domain
	pcs_tx_encoder u_tx_encoder (
		.tx_clk      (tx_clk),
		.tx_arst_n_i (tx_arst_n_o),
		.tx_word_i   (tx_word),
		.tx_block_o  (tx_block_o)
	);

endmodule

// File: pcs_tx/pcs_tx_encoder.sv
// Transmit encoder from decoded PCS words to 66-bit blocks, with error block insertion
`timescale 1ns/1ps

module pcs_tx_encoder (
	input  logic                tx_clk,
	input  logic                tx_arst_n_i,
	input  pcs_pkg::pcs_word_s  tx_word_i,
	output pcs_pkg::pcs_block_t tx_block_o
);
	import pcs_pkg::*;

	logic        term_ok;
	logic [7:0]  term_bt;
	logic [3:0]  term_n;    // Count of kept bytes, 0 to 7
	logic [55:0] data_mask;
	logic [55:0] code_mask;
	logic [55:0] term_payload;
	pcs_block_t  block_d;
	pcs_block_t  block_q;

	// Keeps of a terminate must be a run of low bytes
	always_comb begin
		term_ok = 1'b1;
		term_bt = BT_TERM0;
		case (tx_word_i.keep)
			8'h00:   term_bt = BT_TERM0;
			8'h01:   term_bt = BT_TERM1;
			8'h03:   term_bt = BT_TERM2;
			8'h07:   term_bt = BT_TERM3;
			8'h0f:   term_bt = BT_TERM4;
			8'h1f:   term_bt = BT_TERM5;
			8'h3f:   term_bt = BT_TERM6;
			8'h7f:   term_bt = BT_TERM7;
			default: term_ok = 1'b0;
		endcase
	end

	always_comb begin
		term_n = 4'd0;
		for (int i = 0; i < 8; i++) begin
			if (tx_word_i.keep[i])
				term_n = term_n + 4'd1;
		end
	end

	// Data bytes sit at the bottom of the payload, idle codes take the lanes
	// after the terminate, with 7-n zero pad bits in between
	always_comb begin
		data_mask = '0;
		code_mask = '0;
		for (int i = 0; i < 7; i++) begin
			data_mask[8*i +: 8] = {8{tx_word_i.keep[i]}};
		end
		for (int j = 0; j < 8; j++) begin
			if (j > int'(term_n))
				code_mask[7*j +: 7] = '1;
		end
		term_payload = ({8{CC_IDLE}} & code_mask) | (tx_word_i.data[55:0] & data_mask);
	end

	always_comb begin
		block_d = PCS_ERR_BLOCK;
		if (tx_word_i.err) begin
			block_d = PCS_ERR_BLOCK;
		end else if (!tx_word_i.ctrl) begin
			block_d = {tx_word_i.data, SYNC_DATA};
		end else if (tx_word_i.idle) begin
			block_d = PCS_IDLE_BLOCK;
		end else if (tx_word_i.start[0]) begin
			block_d = {tx_word_i.data[63:8], BT_START0, SYNC_CTRL};
		end else if (tx_word_i.start[1]) begin
			// Four idle lanes, then four zero bits ahead of data lanes 5 to 7
			block_d = {tx_word_i.data[63:40], 4'h0, {4{CC_IDLE}}, BT_START4, SYNC_CTRL};
		end else if (tx_word_i.term && term_ok) begin
			block_d = {term_payload, term_bt, SYNC_CTRL};
		end
	end

	always_ff @(posedge tx_clk or negedge tx_arst_n_i) begin
		if (!tx_arst_n_i)
			block_q <= PCS_IDLE_BLOCK;
		else
			block_q <= block_d;
	end

	assign tx_block_o = block_q;

endmodule

// File: design/pcs_loopback.sv
// Loopback word crossing from rx_clk to tx_clk and transmit reset derivation
`timescale 1ns/1ps

module pcs_loopback (
	input  logic               rx_clk,
	input  logic               tx_clk,
	input  logic               arst_n_i,
	input  pcs_pkg::pcs_word_s rx_word_i,
	output logic               tx_arst_n_o,
	output pcs_pkg::pcs_word_s tx_word_o
);
	import pcs_pkg::*;

	logic      rx_rst_n_q;
	logic      tx_rst_n_q;
	pcs_word_s rx_word_q;

	// Reset release walks through one rx_clk flop and two tx_clk flops so that
	// both stages already hold idle words when the transmit side comes out of reset
	always_ff @(posedge rx_clk or negedge arst_n_i) begin
		if (!arst_n_i)
			rx_rst_n_q <= 1'b0;
		else
			rx_rst_n_q <= 1'b1;
	end

	// Assertion follows arst_n_i at once, release is taken on tx_clk
	always_ff @(posedge tx_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tx_rst_n_q  <= 1'b0;
			tx_arst_n_o <= 1'b0;
		end else begin
			tx_rst_n_q  <= rx_rst_n_q;
			tx_arst_n_o <= tx_rst_n_q;
		end
	end

	always_ff @(posedge rx_clk or negedge arst_n_i) begin
		if (!arst_n_i)
			rx_word_q <= PCS_IDLE_WORD;
		else
			rx_word_q <= rx_word_i;
	end

	// The clocks share one frequency, so the phase gap is absorbed by
	// leaving the rx_clk stage stable for a whole cycle before tx_clk samples it
	always_ff @(posedge tx_clk or negedge tx_arst_n_o) begin
		if (!tx_arst_n_o)
			tx_word_o <= PCS_IDLE_WORD;
		else
			tx_word_o <= rx_word_q;
	end

endmodule

// File: pcs_rx/pcs_rx_decoder.sv
// Receive 64b/66b block decoder with frame tracking, registered decoded PCS word output
`timescale 1ns/1ps

module pcs_rx_decoder (
	input  logic                 rx_clk,
	input  logic                 arst_n_i,
	input  pcs_pkg::pcs_block_t  rx_block_i,
	output pcs_pkg::pcs_word_s   rx_word_o
);
	import pcs_pkg::*;

	logic [1:0]  sync;
	logic [7:0]  btype;
	logic [55:0] payload; // Everything after the block type byte
	logic        all_idle;
	logic        is_term;
	logic [2:0]  term_n;
	pcs_keep_t   term_keep;
	pcs_data_t   term_data;
	logic        bad;

	rx_state_e   state_q, state_d;
	pcs_word_s   word_q, word_d;

	assign sync    = rx_block_i[1:0];
	assign btype   = rx_block_i[9:2];
	assign payload = rx_block_i[65:10];

	// An idle block must carry the idle code in all eight lanes
	always_comb begin
		all_idle = 1'b1;
		for (int i = 0; i < 8; i++) begin
			if (payload[7*i +: 7] != CC_IDLE)
				all_idle = 1'b0;
		end
	end

	// Terminate type to number of data bytes ahead of the terminate character
	always_comb begin
		is_term = 1'b1;
		term_n  = 3'd0;
		case (btype)
			BT_TERM0: term_n = 3'd0;
			BT_TERM1: term_n = 3'd1;
			BT_TERM2: term_n = 3'd2;
			BT_TERM3: term_n = 3'd3;
			BT_TERM4: term_n = 3'd4;
			BT_TERM5: term_n = 3'd5;
			BT_TERM6: term_n = 3'd6;
			BT_TERM7: term_n = 3'd7;
			default:  is_term = 1'b0;
		endcase
	end

	assign term_keep = (8'h01 << term_n) - 8'h01;

	// Data bytes of a terminate start right after the type byte
	always_comb begin
		term_data = '0;
		for (int i = 0; i < 7; i++) begin
			if (term_keep[i])
				term_data[8*i +: 8] = payload[8*i +: 8];
		end
	end

	always_comb begin
		word_d  = PCS_IDLE_WORD;
		state_d = state_q;
		bad     = 1'b0;
		case (sync)
			SYNC_DATA: begin
				if (state_q == RX_FRAME) begin
					word_d.ctrl = 1'b0;
					word_d.idle = 1'b0;
					word_d.data = rx_block_i[65:2];
					word_d.keep = '1;
				end else begin
					bad = 1'b1; // Data with no open frame
				end
			end
			SYNC_CTRL: begin
				if (btype == BT_IDLE) begin
					bad = (state_q != RX_IDLE) || !all_idle;
				end else if (btype == BT_START0 || btype == BT_START4) begin
					if (state_q == RX_IDLE) begin
						word_d.idle = 1'b0;
						state_d     = RX_FRAME;
						if (btype == BT_START0) begin
							word_d.start = 2'b01;
							word_d.data  = {payload, 8'h00}; // Lane 0 holds the start character
							word_d.keep  = 8'hfe;
						end else begin
							word_d.start = 2'b10;
							word_d.data  = {payload[55:32], 40'h0};
							word_d.keep  = 8'he0;
						end
					end else begin
						bad = 1'b1; // Start while a frame is still open
					end
				end else if (is_term && state_q == RX_FRAME) begin
					word_d.idle = 1'b0;
					word_d.term = 1'b1;
					word_d.data = term_data;
					word_d.keep = term_keep;
					state_d     = RX_IDLE;
				end else begin
					bad = 1'b1; // Unknown type or terminate outside a frame
				end
			end
			default: bad = 1'b1; // Sync headers 00 and 11 are never valid
		endcase

		if (bad) begin
			word_d  = PCS_ERR_WORD;
			state_d = RX_IDLE;
		end
	end

	always_ff @(posedge rx_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= RX_IDLE;
			word_q  <= PCS_IDLE_WORD;
		end else begin
			state_q <= state_d;
			word_q  <= word_d;
		end
	end

	assign rx_word_o = word_q;

endmodule

// File: common/pcs_pkg.sv
// Shared PCS widths, sync headers, block-type and control codes, vector types and the decoded word
package pcs_pkg;

	localparam int PCS_DATA_W  = 64;
	localparam int PCS_KEEP_W  = 8;
	localparam int PCS_START_W = 2; // Bit 0 is a start at lane 0, bit 1 a start at lane 4
	localparam int PCS_BLOCK_W = 66;

	// Bit 0 goes first on the line, so "01" in transmission order reads as 2'b10
	localparam logic [1:0] SYNC_DATA = 2'b10;
	localparam logic [1:0] SYNC_CTRL = 2'b01;

	localparam logic [7:0] BT_IDLE   = 8'h1e;
	localparam logic [7:0] BT_START0 = 8'h78;
	localparam logic [7:0] BT_START4 = 8'h33; // Idles in lanes 0 to 3, start in lane 4

	// Terminates, the suffix is the number of data bytes before the terminate character
	localparam logic [7:0] BT_TERM0 = 8'h87;
	localparam logic [7:0] BT_TERM1 = 8'h99;
	localparam logic [7:0] BT_TERM2 = 8'haa;
	localparam logic [7:0] BT_TERM3 = 8'hb4;
	localparam logic [7:0] BT_TERM4 = 8'hcc;
	localparam logic [7:0] BT_TERM5 = 8'hd2;
	localparam logic [7:0] BT_TERM6 = 8'he1;
	localparam logic [7:0] BT_TERM7 = 8'hff;

	localparam logic [6:0] CC_IDLE  = 7'h00;
	localparam logic [6:0] CC_ERROR = 7'h1e;

	typedef logic [PCS_BLOCK_W-1:0] pcs_block_t; // Sync header in [1:0], payload above it
	typedef logic [PCS_DATA_W-1:0]  pcs_data_t;
	typedef logic [PCS_KEEP_W-1:0]  pcs_keep_t;
	typedef logic [PCS_START_W-1:0] pcs_start_t;

	// Decoded word as it travels from the receive decoder to the transmit encoder
	typedef struct packed {
		logic       ctrl;
		logic       idle;
		logic       term;
		logic       err;
		pcs_start_t start;
		pcs_data_t  data; // Lane n sits in data[8n+7:8n]
		pcs_keep_t  keep;
	} pcs_word_s;

	typedef enum logic {
		RX_IDLE,
		RX_FRAME
	} rx_state_e;

	localparam pcs_word_s PCS_IDLE_WORD = '{ctrl: 1'b1, idle: 1'b1, term: 1'b0, err: 1'b0,
		start: '0, data: '0, keep: '0};

	localparam pcs_word_s PCS_ERR_WORD = '{ctrl: 1'b1, idle: 1'b0, term: 1'b0, err: 1'b1,
		start: '0, data: '0, keep: '0};

	// Control blocks carrying eight idle or eight error codes
	localparam pcs_block_t PCS_IDLE_BLOCK = {{8{CC_IDLE}}, BT_IDLE, SYNC_CTRL};
	localparam pcs_block_t PCS_ERR_BLOCK  = {{8{CC_ERROR}}, BT_IDLE, SYNC_CTRL};

endpackage
